//--- rtl/mem_consts.svh
// data path width, register index width and data memory depth
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// integer data path width
`define XLEN 32

// x0..x31
`define REG_ADDR_W 5

// default data memory size, in words
`define DMEM_DEPTH_LOG2 10

`endif

//--- rtl/mem_stage_pkg.sv
// memory stage types: data word, register index and memory operation codes
`include "mem_consts.svh"

package mem_stage_pkg;

    // addresses, store data, load data and register contents
    typedef logic [`XLEN-1:0] xword_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation handed over from EX/MEM
    typedef enum logic [3:0]
    {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LBU = 4'd2,
        MEM_LH  = 4'd3,
        MEM_LHU = 4'd4,
        MEM_LW  = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_oper_t;

endpackage : mem_stage_pkg

//--- rtl/dmem_if.sv
// data memory port between the load/store unit and the RAM
`timescale 1ns/1ps

interface dmem_if
    import mem_stage_pkg::*;
();

    // read side
    xword_t     addr;
    logic       read;
    xword_t     rdata;

    // write side, one enable per byte lane
    logic [3:0] wsel_byte;
    xword_t     wdata;

    modport master (output addr, output read, output wsel_byte, output wdata,
                    input rdata);

    modport slave (input addr, input read, input wsel_byte, input wdata,
                   output rdata);

endinterface : dmem_if

//--- rtl/mem_wb_if.sv
// MEM/WB pipeline register contents
`timescale 1ns/1ps

interface mem_wb_if
    import mem_stage_pkg::*;
();

    // writeback control
    logic      wb_use_mem;
    logic      write_rd;
    reg_addr_t rd_addr;

    // candidate writeback values
    xword_t    alu_result;
    xword_t    dmem_rdata;

    modport source (output wb_use_mem, output write_rd, output rd_addr,
                    output alu_result, output dmem_rdata);

    modport sink (input wb_use_mem, input write_rd, input rd_addr,
                  input alu_result, input dmem_rdata);

endinterface : mem_wb_if

//--- rtl/mem_rw.sv
// load/store unit: byte lane steering, load extension and MEM/WB registers
`timescale 1ns/1ps

module mem_rw
    import mem_stage_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,

    // from EX/MEM
    input  mem_oper_t mem_oper_i,
    input  xword_t    alu_result_i,
    input  xword_t    alu_oper2_i,

    // only passed on to WB
    input  logic      wb_use_mem_i,
    input  logic      write_rd_i,
    input  reg_addr_t rd_addr_i,

    dmem_if.master    dmem,
    mem_wb_if.source  mem_wb
);

    logic [4:0] byte_shift;
    xword_t     rd_lane;
    xword_t     load_data;
    xword_t     wdata;
    logic [3:0] wsel_byte;
    logic       read;

    // bit offset of the addressed byte inside the word
    assign byte_shift = {alu_result_i[1:0], 3'b000};

    // addressed byte or halfword moved down to bit 0
    assign rd_lane = dmem.rdata >> byte_shift;

    always_comb
    begin
        read      = 1'b0;
        wsel_byte = 4'b0000;
        wdata     = '0;
        load_data = '0;

        case (mem_oper_i)
            MEM_LB:
            begin
                read      = 1'b1;
                load_data = xword_t'(signed'(rd_lane[7:0]));
            end
            MEM_LBU:
            begin
                read      = 1'b1;
                load_data = xword_t'(rd_lane[7:0]);
            end
            MEM_LH:
            begin
                read      = 1'b1;
                load_data = xword_t'(signed'(rd_lane[15:0]));
            end
            MEM_LHU:
            begin
                read      = 1'b1;
                load_data = xword_t'(rd_lane[15:0]);
            end
            MEM_LW:
            begin
                read      = 1'b1;
                load_data = dmem.rdata;
            end

            // stores shift the data up to the addressed lanes
            MEM_SB:
            begin
                wsel_byte = 4'b0001 << alu_result_i[1:0];
                wdata     = alu_oper2_i << byte_shift;
            end
            MEM_SH:
            begin
                wsel_byte = 4'b0011 << {alu_result_i[1], 1'b0};
                wdata     = alu_oper2_i << byte_shift;
            end
            MEM_SW:
            begin
                wsel_byte = 4'b1111;
                wdata     = alu_oper2_i;
            end

            default:
            begin
                read = 1'b0;
            end
        endcase
    end

    // address held at zero on idle cycles
    assign dmem.addr      = (mem_oper_i != MEM_NOP) ? alu_result_i : '0;
    assign dmem.read      = read;
    assign dmem.wsel_byte = wsel_byte;
    assign dmem.wdata     = wdata;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            mem_wb.wb_use_mem <= 1'b0;
            mem_wb.write_rd   <= 1'b0;
            mem_wb.rd_addr    <= '0;
            mem_wb.alu_result <= '0;
            mem_wb.dmem_rdata <= '0;
        end
        else
        begin
            mem_wb.wb_use_mem <= wb_use_mem_i;
            mem_wb.write_rd   <= write_rd_i;
            mem_wb.rd_addr    <= rd_addr_i;
            mem_wb.alu_result <= alu_result_i;
            mem_wb.dmem_rdata <= load_data;
        end
    end

    // unaligned accesses are not split, so they must never reach this stage
    a_half_aligned : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_oper_i inside {MEM_LH, MEM_LHU, MEM_SH}) |-> !alu_result_i[0])
        else $error("mem_rw: unaligned halfword access at %h", alu_result_i);

    a_word_aligned : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_oper_i inside {MEM_LW, MEM_SW}) |-> (alu_result_i[1:0] == 2'b00))
        else $error("mem_rw: unaligned word access at %h", alu_result_i);

    // the RAM sees either a read or a write in one cycle
    a_rw_exclusive : assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(dmem.read && (|dmem.wsel_byte)))
        else $error("mem_rw: read and write strobes both active");

endmodule : mem_rw

//--- rtl/data_memory.sv
// data RAM: asynchronous read, byte-enabled synchronous write
`timescale 1ns/1ps
`include "mem_consts.svh"

module data_memory
    import mem_stage_pkg::*;
#(
    parameter int DEPTH_LOG2 = `DMEM_DEPTH_LOG2
)
(
    input logic  clk_i,
    input logic  rstn_i,
    dmem_if.slave bus
);

    xword_t                  mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0]   word_idx;

    // byte address to word index
    assign word_idx = bus.addr[DEPTH_LOG2+1:2];

    // read data only driven while a load is in flight
    assign bus.rdata = bus.read ? mem[word_idx] : '0;

    always_ff @(posedge clk_i)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (bus.wsel_byte[i])
            begin
                mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end

    // upper address bits are dropped by the indexing, so they have to be zero
    a_in_range : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (bus.read || (|bus.wsel_byte)) |-> ((bus.addr >> (DEPTH_LOG2 + 2)) == '0))
        else $error("data_memory: address %h beyond %0d words", bus.addr,
                    2**DEPTH_LOG2);

endmodule : data_memory

//--- rtl/wb_regfile.sv
// writeback select and integer register file with a debug read port
`timescale 1ns/1ps
`include "mem_consts.svh"

module wb_regfile
    import mem_stage_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,

    mem_wb_if.sink    mem_wb,

    // debug read port
    input  reg_addr_t dbg_raddr_i,
    output xword_t    dbg_rdata_o,

    // writeback observation
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output xword_t    wb_data_o
);

    localparam int NUM_REGS = 2**`REG_ADDR_W;

    xword_t regs [NUM_REGS];
    xword_t wb_data;
    logic   rf_we;

    // load result or ALU result
    assign wb_data = mem_wb.wb_use_mem ? mem_wb.dmem_rdata : mem_wb.alu_result;

    // x0 is hardwired, never written
    assign rf_we = mem_wb.write_rd && (mem_wb.rd_addr != '0);

    assign wb_we_o   = mem_wb.write_rd;
    assign wb_rd_o   = mem_wb.rd_addr;
    assign wb_data_o = wb_data;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rf_we)
        begin
            regs[mem_wb.rd_addr] <= wb_data;
        end
    end

    assign dbg_rdata_o = (dbg_raddr_i == '0) ? '0 : regs[dbg_raddr_i];

    // a cycle without a writeback request leaves every register as it was
    for (genvar g = 1; g < NUM_REGS; g++)
    begin : g_hold_chk
        a_reg_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
            !mem_wb.write_rd |=> $stable(regs[g]))
            else $error("wb_regfile: x%0d changed without write_rd", g);
    end

endmodule : wb_regfile

//--- rtl/mem_wb_top.sv
// memory access stage top: load/store unit, data RAM and writeback register file
`timescale 1ns/1ps

module mem_wb_top
    import mem_stage_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,

    // from EX/MEM
    input  mem_oper_t mem_oper_i,
    input  xword_t    alu_result_i,
    input  xword_t    alu_oper2_i,
    input  logic      wb_use_mem_i,
    input  logic      write_rd_i,
    input  reg_addr_t rd_addr_i,

    // register file debug read
    input  reg_addr_t dbg_raddr_i,
    output xword_t    dbg_rdata_o,

    // writeback observation
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output xword_t    wb_data_o
);

    dmem_if   dmem_bus ();
    mem_wb_if mem_wb_bus ();

    mem_rw u_mem_rw
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .mem_oper_i   (mem_oper_i),
        .alu_result_i (alu_result_i),
        .alu_oper2_i  (alu_oper2_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .dmem         (dmem_bus.master),
        .mem_wb       (mem_wb_bus.source)
    );

    data_memory u_data_memory
    (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .bus    (dmem_bus.slave)
    );

    wb_regfile u_wb_regfile
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .mem_wb      (mem_wb_bus.sink),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o),
        .wb_we_o     (wb_we_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

endmodule : mem_wb_top

//--- testbench/tb_mem_stage.sv
// testbench for mem_wb_top: reference models, directed and random tests, watchdog
`timescale 1ns/1ps

module tb_mem_stage
    import mem_stage_pkg::*;
();

    localparam int     CLK_PERIOD   = 10;
    localparam int     RAND_OPS     = 300;
    // directed cycles including drains and register sweeps
    localparam int     DIRECTED_OPS = 220;
    localparam int     TOTAL_OPS    = 4 + DIRECTED_OPS + RAND_OPS;
    localparam xword_t POOL_BASE    = 32'h400;

    typedef struct packed
    {
        logic      we;
        reg_addr_t rd;
        xword_t    data;
    } wb_exp_t;

    logic      clk_i;
    logic      rstn_i;
    mem_oper_t mem_oper_i;
    xword_t    alu_result_i;
    xword_t    alu_oper2_i;
    logic      wb_use_mem_i;
    logic      write_rd_i;
    reg_addr_t rd_addr_i;
    reg_addr_t dbg_raddr_i;
    xword_t    dbg_rdata_o;
    logic      wb_we_o;
    reg_addr_t wb_rd_o;
    xword_t    wb_data_o;

    // reference state
    xword_t    mem_model [int];
    xword_t    reg_model [32];
    wb_exp_t   exp_q [$];
    string     name_q [$];
    wb_exp_t   cmp_exp;
    string     cmp_name;
    string     cur_test;
    int        err_count;
    int        test_err_base;
    int        tests_ok;
    int        tests_bad;
    int        seed = 32'h88e7;

    mem_wb_top DUT
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .mem_oper_i   (mem_oper_i),
        .alu_result_i (alu_result_i),
        .alu_oper2_i  (alu_oper2_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .dbg_raddr_i  (dbg_raddr_i),
        .dbg_rdata_o  (dbg_rdata_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic is_load(input mem_oper_t op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

    function automatic logic is_store(input mem_oper_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    // lane pick plus sign or zero extension
    function automatic xword_t ref_load(input mem_oper_t op, input xword_t word,
                                        input xword_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        xword_t      res;
        b   = 8'(word >> (8 * int'(addr[1:0])));
        h   = 16'(word >> (16 * int'(addr[1])));
        res = word;
        case (op)
            MEM_LB:  res = {{24{b[7]}}, b};
            MEM_LBU: res = {24'h0, b};
            MEM_LH:  res = {{16{h[15]}}, h};
            MEM_LHU: res = {16'h0, h};
            default: res = word;
        endcase
        return res;
    endfunction

    // merge the stored lanes into the old word
    function automatic xword_t ref_store(input mem_oper_t op, input xword_t old,
                                         input xword_t data, input xword_t addr);
        xword_t mask;
        int     sh;
        sh   = 8 * int'(addr[1:0]);
        mask = 32'hFFFF_FFFF;
        case (op)
            MEM_SB:  mask = 32'h0000_00FF << sh;
            MEM_SH:  mask = 32'h0000_FFFF << sh;
            default: mask = 32'hFFFF_FFFF;
        endcase
        return (old & ~mask) | ((data << sh) & mask);
    endfunction

    task automatic check_flag(input string tname, input string what, input logic exp,
                              input logic act);
        if (act !== exp)
        begin
            err_count++;
            $display("Error %s: %s expected %b, actual %b", tname, what, exp, act);
        end
    endtask

    task automatic check_reg_addr(input string tname, input reg_addr_t exp,
                                  input reg_addr_t act);
        if (act !== exp)
        begin
            err_count++;
            $display("Error %s: wb_rd expected x%0d, actual x%0d", tname, exp, act);
        end
    endtask

    task automatic check_xword(input string tname, input string what, input xword_t exp,
                               input xword_t act);
        if (act !== exp)
        begin
            err_count++;
            $display("Error %s: %s expected %h, actual %h", tname, what, exp, act);
        end
    endtask

    // one MEM cycle, expected writeback queued for the compare process
    task automatic drive_op(input mem_oper_t op, input xword_t addr, input xword_t data,
                            input logic use_mem, input logic wr, input reg_addr_t rd);
        wb_exp_t e;
        int      widx;
        xword_t  old;
        @(negedge clk_i);
        mem_oper_i   = op;
        alu_result_i = addr;
        alu_oper2_i  = data;
        wb_use_mem_i = use_mem;
        write_rd_i   = wr;
        rd_addr_i    = rd;
        widx = int'(addr >> 2);
        old  = mem_model.exists(widx) ? mem_model[widx] : '0;
        if (is_store(op))
        begin
            mem_model[widx] = ref_store(op, old, data, addr);
        end
        e.we   = wr;
        e.rd   = rd;
        e.data = (use_mem && is_load(op)) ? ref_load(op, old, addr) : addr;
        exp_q.push_back(e);
        name_q.push_back(cur_test);
    endtask

    // registered writeback is stable a little after the rising edge
    always @(posedge clk_i)
    begin
        if (rstn_i && (exp_q.size() > 0))
        begin
            #2;
            cmp_exp  = exp_q.pop_front();
            cmp_name = name_q.pop_front();
            check_flag(cmp_name, "wb_we", cmp_exp.we, wb_we_o);
            check_reg_addr(cmp_name, cmp_exp.rd, wb_rd_o);
            check_xword(cmp_name, "wb_data", cmp_exp.data, wb_data_o);
            if (cmp_exp.we && (cmp_exp.rd != '0))
            begin
                reg_model[cmp_exp.rd] = cmp_exp.data;
            end
        end
    end

    task automatic drain();
        drive_op(MEM_NOP, '0, '0, 1'b0, 1'b0, '0);
        drive_op(MEM_NOP, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic read_reg_check(input reg_addr_t r);
        drive_op(MEM_NOP, '0, '0, 1'b0, 1'b0, '0);
        dbg_raddr_i = r;
        #1;
        check_xword(cur_test, $sformatf("x%0d", r), reg_model[r], dbg_rdata_o);
    endtask

    task automatic sweep_regs();
        drain();
        for (int i = 0; i < 32; i++)
        begin
            read_reg_check(reg_addr_t'(i));
        end
    endtask

    task automatic start_test(input string tname);
        cur_test      = tname;
        test_err_base = err_count;
    endtask

    task automatic end_test();
        int n;
        drain();
        @(posedge clk_i);
        #3;
        n = err_count - test_err_base;
        if (n == 0)
        begin
            tests_ok++;
        end
        else
        begin
            tests_bad++;
        end
        $display("test %-12s %s, %0d errors", cur_test, (n == 0) ? "ok" : "FAILED", n);
    endtask

    task automatic test_store_merge();
        xword_t    base;
        mem_oper_t op;
        int        off;
        start_test("store_merge");
        for (int c = 0; c < 7; c++)
        begin
            op  = (c < 4) ? MEM_SB : ((c < 6) ? MEM_SH : MEM_SW);
            off = (c < 4) ? c : ((c < 6) ? 2 * (c - 4) : 0);
            base = 32'h200 + 4 * c;
            drive_op(MEM_SW, base, $random(seed), 1'b0, 1'b0, '0);
            drive_op(op, base + xword_t'(off), $random(seed), 1'b0, 1'b0, '0);
            // load right behind the store
            drive_op(MEM_LW, base, '0, 1'b1, 1'b1, reg_addr_t'(c + 1));
        end
        end_test();
    endtask

    task automatic test_load_extend();
        xword_t    pat [2];
        xword_t    base;
        reg_addr_t rd;
        start_test("load_extend");
        pat[0] = 32'h8F80_FF81;
        pat[1] = 32'h7F01_7E3C;
        rd     = 5'd1;
        for (int w = 0; w < 2; w++)
        begin
            base = 32'h300 + 8 * w;
            drive_op(MEM_SW, base, pat[w], 1'b0, 1'b0, '0);
            for (int off = 0; off < 4; off++)
            begin
                drive_op(MEM_LB, base + xword_t'(off), '0, 1'b1, 1'b1, rd);
                rd = rd + 1'b1;
                drive_op(MEM_LBU, base + xword_t'(off), '0, 1'b1, 1'b1, rd);
                rd = rd + 1'b1;
            end
            for (int off = 0; off < 4; off += 2)
            begin
                drive_op(MEM_LH, base + xword_t'(off), '0, 1'b1, 1'b1, rd);
                rd = rd + 1'b1;
                drive_op(MEM_LHU, base + xword_t'(off), '0, 1'b1, 1'b1, rd);
                rd = rd + 1'b1;
            end
        end
        sweep_regs();
        end_test();
    endtask

    task automatic test_alu_path();
        start_test("alu_path");
        drive_op(MEM_NOP, $random(seed), '0, 1'b0, 1'b1, 5'd5);
        drive_op(MEM_NOP, $random(seed), '0, 1'b0, 1'b0, 5'd6);
        drive_op(MEM_NOP, $random(seed), '0, 1'b0, 1'b1, 5'd0);
        // a load with wb_use_mem low still writes the address
        drive_op(MEM_LW, 32'h300, '0, 1'b0, 1'b1, 5'd7);
        sweep_regs();
        end_test();
    endtask

    task automatic test_random_mix();
        int        kind;
        int        off;
        xword_t    addr;
        xword_t    data;
        xword_t    flags;
        mem_oper_t op;
        logic      use_mem;
        logic      wr;
        start_test("random_mix");
        // every pool word is defined before the first load
        for (int i = 0; i < 16; i++)
        begin
            drive_op(MEM_SW, POOL_BASE + 4 * i, $random(seed), 1'b0, 1'b0, '0);
        end
        for (int n = 0; n < RAND_OPS; n++)
        begin
            kind  = int'($unsigned($random(seed)) % 9);
            addr  = POOL_BASE + xword_t'(4 * int'($unsigned($random(seed)) % 16));
            off   = int'($unsigned($random(seed)) % 4);
            data  = $random(seed);
            flags = $random(seed);
            op    = mem_oper_t'(4'(kind));
            use_mem = 1'b0;
            wr      = 1'b0;
            if (op == MEM_NOP)
            begin
                addr = data;
                wr   = flags[0];
            end
            else if (op inside {MEM_LH, MEM_LHU, MEM_SH})
            begin
                addr = addr + xword_t'(off & 2);
            end
            else if (op inside {MEM_LB, MEM_LBU, MEM_SB})
            begin
                addr = addr + xword_t'(off);
            end
            if (is_load(op))
            begin
                use_mem = 1'b1;
                wr      = flags[0] | flags[1];
            end
            drive_op(op, addr, data, use_mem, wr, reg_addr_t'(flags[12:8]));
        end
        sweep_regs();
        end_test();
    endtask

    initial
    begin
        #(TOTAL_OPS * CLK_PERIOD * 4);
        $display("watchdog: the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        rstn_i       = 1'b0;
        mem_oper_i   = MEM_NOP;
        alu_result_i = '0;
        alu_oper2_i  = '0;
        wb_use_mem_i = 1'b0;
        write_rd_i   = 1'b0;
        rd_addr_i    = '0;
        dbg_raddr_i  = '0;
        err_count    = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        cur_test     = "reset_state";
        for (int i = 0; i < 32; i++)
        begin
            reg_model[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        start_test("reset_state");
        check_flag(cur_test, "wb_we after reset", 1'b0, wb_we_o);
        check_xword(cur_test, "wb_data after reset", '0, wb_data_o);
        sweep_regs();
        end_test();

        test_store_merge();
        test_load_extend();
        test_alu_path();
        test_random_mix();

        $display("%0d tests: %0d ok, %0d failed, %0d check errors",
                 tests_ok + tests_bad, tests_ok, tests_bad, err_count);
        if ((err_count == 0) && (tests_bad == 0))
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_mem_stage

//--- tb.f
+incdir+rtl
rtl/mem_stage_pkg.sv
rtl/dmem_if.sv
rtl/mem_wb_if.sv
rtl/mem_rw.sv
rtl/data_memory.sv
rtl/wb_regfile.sv
rtl/mem_wb_top.sv
testbench/tb_mem_stage.sv

//--- Makefile
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := rtl/mem_consts.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
